// File: Makefile
TOP := tb_rv_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f compile.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -qx "TB PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir sim.log

// File: compile.f
rv_pkg.sv
inst_decoder.sv
reg_file.sv
rv_core.sv
mem_system.sv
rv_top.sv
rv_top_assertions.sv
tb_rv_top.sv

// File: inst_decoder.sv
module inst_decoder import rv_pkg::*; (
    input  inst_u inst,
    output dec_t  dec
);

    logic  is_lui;
    logic  is_auipc;
    logic  is_jal;
    logic  is_jalr;
    logic  is_add;
    logic  is_addi;
    logic  is_lw;
    logic  is_lbu;
    logic  is_sw;
    logic  is_sb;
    logic  is_ebreak;
    logic  is_legal;
    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    word_t imm_j;

    // u and j types need only the opcode
    assign is_lui   = inst.u_fmt.opcode == op_lui;
    assign is_auipc = inst.u_fmt.opcode == op_auipc;
    assign is_jal   = inst.j_fmt.opcode == op_jal;
    // funct3 zero for jalr and addi
    assign is_jalr  = inst.i_fmt.opcode == op_jalr && inst.i_fmt.funct3 == 3'b000;
    assign is_addi  = inst.i_fmt.opcode == op_imm && inst.i_fmt.funct3 == 3'b000;
    // add, funct7 must be zero as well
    assign is_add   = inst.r_fmt.opcode == op_op && inst.r_fmt.funct3 == 3'b000
                      && inst.r_fmt.funct7 == 7'b0000000;
    assign is_lw    = inst.i_fmt.opcode == op_load && inst.i_fmt.funct3 == 3'b010;
    assign is_lbu   = inst.i_fmt.opcode == op_load && inst.i_fmt.funct3 == 3'b100;
    assign is_sw    = inst.s_fmt.opcode == op_store && inst.s_fmt.funct3 == 3'b010;
    assign is_sb    = inst.s_fmt.opcode == op_store && inst.s_fmt.funct3 == 3'b000;
    // ebreak has exactly one encoding
    assign is_ebreak = inst == inst_u'(32'h0010_0073);

    assign is_legal = is_lui | is_auipc | is_jal | is_jalr | is_add | is_addi
                    | is_lw | is_lbu | is_sw | is_sb | is_ebreak;

    // sign extended immediates per format
    assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
    assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
    assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        // register fields sit in the same place in every format
        dec.rd  = inst.r_fmt.rd;
        dec.rs1 = inst.r_fmt.rs1;
        dec.rs2 = inst.r_fmt.rs2;

        if (is_addi || is_jalr || is_lw || is_lbu) begin
            dec.imm = imm_i;
        end else if (is_sw || is_sb) begin
            dec.imm = imm_s;
        end else if (is_lui || is_auipc) begin
            dec.imm = imm_u;
        end else if (is_jal) begin
            dec.imm = imm_j;
        end else begin
            dec.imm = '0;
        end

        // illegal words write nothing
        dec.reg_wen = is_lui | is_auipc | is_jal | is_jalr | is_add | is_addi
                    | is_lw | is_lbu;

        if (is_lw || is_lbu) begin
            dec.wb_sel = wb_mem;
        end else if (is_jal || is_jalr) begin
            dec.wb_sel = wb_pc4;
        end else if (is_lui) begin
            dec.wb_sel = wb_imm;
        end else begin
            dec.wb_sel = wb_alu;
        end

        // auipc adds to pc, addi and auipc take the immediate
        dec.src1_pc    = is_auipc;
        dec.src2_imm   = is_addi | is_auipc;
        dec.is_load    = is_lw | is_lbu;
        dec.load_byte  = is_lbu;
        dec.is_store   = is_sw | is_sb;
        dec.store_byte = is_sb;
        dec.is_jal     = is_jal;
        dec.is_jalr    = is_jalr;
        dec.is_ebreak  = is_ebreak;
        dec.illegal    = ~is_legal;
    end

endmodule

// File: mem_system.sv
module mem_system import rv_pkg::*; #(
    parameter int    MEM_WORDS = 2048,
    parameter word_t RESET_PC  = 32'h8000_0000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  word_t                        fetch_addr,
    output inst_u                        fetch_data,
    input  word_t                        data_addr,
    output word_t                        data_rdata,
    input  store_t                       data_wr,
    input  logic                         load_en,
    input  logic [$clog2(MEM_WORDS)-1:0] load_index,
    input  word_t                        load_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t             mem [MEM_WORDS];
    logic [IDX_W-1:0]  fetch_idx;
    logic [IDX_W-1:0]  data_idx;
    logic [IDX_W-1:0]  wr_idx;

    // byte address to word slot, wrapping past the end
    function automatic logic [IDX_W-1:0] word_index(input word_t addr);
        word_t off;
        off = addr - RESET_PC;
        return IDX_W'((off >> 2) % word_t'(MEM_WORDS));
    endfunction

    assign fetch_idx = word_index(fetch_addr);
    assign data_idx  = word_index(data_addr);
    assign wr_idx    = word_index(data_wr.addr);

    // both read ports combinational
    assign fetch_data = mem[fetch_idx];
    assign data_rdata = mem[data_idx];

    // loader only while reset, core stores otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            if (load_en) begin
                mem[load_index] <= load_data;
            end
        end else if (data_wr.valid) begin
            for (int b = 0; b < 4; b++) begin
                if (data_wr.mask[b]) begin
                    mem[wr_idx][8*b +: 8] <= data_wr.data[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: reg_file.sv
module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [32];

    // x0 never stored
    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: rv_core.sv
module rv_core import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h8000_0000
) (
    input  logic    clk,
    input  logic    reset,
    output word_t   fetch_addr,
    input  inst_u   fetch_data,
    output word_t   data_addr,
    input  word_t   data_rdata,
    output store_t  data_wr,
    output retire_t retire,
    output logic    halted
);

    word_t pc;
    word_t next_pc;
    word_t pc_plus4;
    dec_t  dec;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_a;
    word_t alu_b;
    word_t alu_sum;
    word_t eff_addr;
    word_t shifted_rdata;
    word_t load_val;
    word_t wb_data;
    logic  active;
    logic  halt_now;

    inst_decoder u_dec (
        .inst (fetch_data),
        .dec  (dec)
    );

    reg_file u_regs (
        .clk    (clk),
        .wen    (dec.reg_wen & active),
        .waddr  (dec.rd),
        .wdata  (wb_data),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // one instruction per cycle unless in reset or halted
    assign active   = ~reset & ~halted;
    assign halt_now = active & (dec.is_ebreak | dec.illegal);

    assign fetch_addr = pc;
    assign pc_plus4   = pc + 32'd4;

    // operand muxes and the single adder
    assign alu_a   = dec.src1_pc ? pc : rs1_data;
    assign alu_b   = dec.src2_imm ? dec.imm : rs2_data;
    assign alu_sum = alu_a + alu_b;

    // address adder, shared by loads, stores and jalr
    assign eff_addr  = rs1_data + dec.imm;
    assign data_addr = eff_addr;

    // lbu picks the addressed byte lane
    assign shifted_rdata = data_rdata >> {eff_addr[1:0], 3'b000};
    assign load_val      = dec.load_byte ? {24'b0, shifted_rdata[7:0]} : data_rdata;

    always_comb begin
        case (dec.wb_sel)
            wb_mem:  wb_data = load_val;
            wb_pc4:  wb_data = pc_plus4;
            wb_imm:  wb_data = dec.imm;
            default: wb_data = alu_sum;
        endcase
    end

    // jalr target has bit 0 cleared
    always_comb begin
        if (dec.is_jal) begin
            next_pc = pc + dec.imm;
        end else if (dec.is_jalr) begin
            next_pc = {eff_addr[31:1], 1'b0};
        end else begin
            next_pc = pc_plus4;
        end
    end

    // pc stays on the halting instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else if (halt_now) begin
            halted <= 1'b1;
        end else if (active) begin
            pc <= next_pc;
        end
    end

    // sb replicates the byte, mask picks the lane
    assign data_wr.valid = active & dec.is_store;
    assign data_wr.addr  = eff_addr;
    assign data_wr.data  = dec.store_byte ? {4{rs2_data[7:0]}} : rs2_data;
    assign data_wr.mask  = dec.store_byte ? (4'b0001 << eff_addr[1:0]) : 4'b1111;

    // rd_wen only when a register really changes
    assign retire.valid   = active;
    assign retire.pc      = pc;
    assign retire.rd_wen  = active & dec.reg_wen & (dec.rd != 5'd0);
    assign retire.rd      = dec.rd;
    assign retire.rd_data = wb_data;

endmodule

// File: rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_op     = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_system = 7'b1110011
    } opcode_e;

    // one instruction word, seen through every format at once
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            opcode_e    opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            opcode_e     opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            opcode_e    opcode;
        } s_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            reg_idx_t    rd;
            opcode_e     opcode;
        } u_fmt;
        // jump immediate bits in their encoded order
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            reg_idx_t   rd;
            opcode_e    opcode;
        } j_fmt;
    } inst_u;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4,
        wb_imm
    } wb_sel_e;

    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        logic     reg_wen;
        wb_sel_e  wb_sel;
        logic     src1_pc;
        logic     src2_imm;
        logic     is_load;
        logic     load_byte;
        logic     is_store;
        logic     store_byte;
        logic     is_jal;
        logic     is_jalr;
        logic     is_ebreak;
        logic     illegal;
    } dec_t;

    // one retired instruction
    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     rd_wen;
        reg_idx_t rd;
        word_t    rd_data;
    } retire_t;

    // one store, byte lanes already placed
    typedef struct packed {
        logic       valid;
        word_t      addr;
        word_t      data;
        logic [3:0] mask;
    } store_t;

endpackage

// File: rv_top.sv
module rv_top import rv_pkg::*; #(
    parameter int    MEM_WORDS = 2048,
    parameter word_t RESET_PC  = 32'h8000_0000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load_en,
    input  logic [$clog2(MEM_WORDS)-1:0] load_index,
    input  word_t                        load_data,
    output retire_t                      retire,
    output store_t                       store,
    output logic                         halted
);

    word_t fetch_addr;
    inst_u fetch_data;
    word_t data_addr;
    word_t data_rdata;

    // store port doubles as the core to memory write bus
    rv_core #(
        .RESET_PC (RESET_PC)
    ) u_core (
        .clk        (clk),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_addr  (data_addr),
        .data_rdata (data_rdata),
        .data_wr    (store),
        .retire     (retire),
        .halted     (halted)
    );

    mem_system #(
        .MEM_WORDS (MEM_WORDS),
        .RESET_PC  (RESET_PC)
    ) u_mem (
        .clk        (clk),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_addr  (data_addr),
        .data_rdata (data_rdata),
        .data_wr    (store),
        .load_en    (load_en),
        .load_index (load_index),
        .load_data  (load_data)
    );

endmodule

// File: rv_top_assertions.sv
module rv_top_assertions import rv_pkg::*; (
    input logic    clk,
    input logic    reset,
    input retire_t retire,
    input store_t  store,
    input logic    halted
);

    timeunit 1ns;
    timeprecision 100ps;

    // failures seen by the action blocks
    int fail_count = 0;

    // reset keeps the core silent
    quiet_in_reset: assert property (@(posedge clk) reset |-> !retire.valid && !store.valid)
        else begin
            fail_count++;
            $error("retire or store valid while reset is high");
        end

    no_retire_halted: assert property (@(posedge clk) halted |-> !retire.valid)
        else begin
            fail_count++;
            $error("instruction retired while halted");
        end

    // only reset leaves the halt state
    halt_sticky: assert property (@(posedge clk) halted && !reset |=> halted)
        else begin
            fail_count++;
            $error("halted dropped without reset");
        end

    store_has_mask: assert property (@(posedge clk) store.valid |-> store.mask != 4'b0000)
        else begin
            fail_count++;
            $error("store valid with an empty byte mask");
        end

endmodule

bind rv_top rv_top_assertions u_assertions (
    .clk    (clk),
    .reset  (reset),
    .retire (retire),
    .store  (store),
    .halted (halted)
);

// File: tb_rv_top.sv
module tb_rv_top import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    PERIOD       = 4;
    localparam int    MEM_WORDS    = 2048;
    localparam word_t RESET_PC     = 32'h8000_0000;
    localparam int    NUM_PROGS    = 4;
    localparam int    PROG_LEN     = 64;
    // word slot of 0x8000_1000, the x1 data base
    localparam int    DATA_BASE    = 1024;
    localparam int    DATA_WORDS   = 512;
    localparam int    RESET_CYCLES = 5;
    localparam int    HALT_CYCLES  = 4;
    localparam int    SLACK        = 20;
    localparam int    LOAD_WORDS   = PROG_LEN + DATA_WORDS;
    localparam int    WATCHDOG_NS  = NUM_PROGS * PERIOD
                                   * (LOAD_WORDS + RESET_CYCLES + PROG_LEN + HALT_CYCLES + SLACK);

    // isa major opcodes
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // instruction kinds of the generated programs
    localparam int K_LUI    = 0;
    localparam int K_AUIPC  = 1;
    localparam int K_JAL    = 2;
    localparam int K_JALR   = 3;
    localparam int K_ADD    = 4;
    localparam int K_ADDI   = 5;
    localparam int K_LW     = 6;
    localparam int K_LBU    = 7;
    localparam int K_SW     = 8;
    localparam int K_SB     = 9;
    localparam int K_EBREAK = 10;

    logic        clk;
    logic        reset;
    logic        load_en;
    logic [10:0] load_index;
    word_t       load_data;
    retire_t     retire;
    store_t      store;
    logic        halted;

    // generated program, one entry per slot
    word_t    prog_word [PROG_LEN];
    int       slot_kind [PROG_LEN];
    reg_idx_t slot_rd   [PROG_LEN];
    reg_idx_t slot_rs1  [PROG_LEN];
    reg_idx_t slot_rs2  [PROG_LEN];
    word_t    slot_imm  [PROG_LEN];
    logic     reg_known [32];
    int       exp_retires;

    // reference model state
    word_t    model_regs [32];
    word_t    model_mem  [MEM_WORDS];
    word_t    model_pc;
    logic     model_halted;

    int       error_count;
    int       retire_count;
    int       store_count;

    rv_top #(
        .MEM_WORDS (MEM_WORDS),
        .RESET_PC  (RESET_PC)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .load_index (load_index),
        .load_data  (load_data),
        .retire     (retire),
        .store      (store),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

    // whole-address fill so every data word differs
    function automatic word_t data_fill(input int slot, input int prog);
        word_t a;
        a = RESET_PC + word_t'(slot) * 32'd4;
        return (a * 32'h9e37_79b9) ^ {8'(prog), 24'h5a_c3_96};
    endfunction

    function automatic word_t encode(input int kind, input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input word_t imm);
        case (kind)
            K_LUI:   return {imm[31:12], rd, OPC_LUI};
            K_AUIPC: return {imm[31:12], rd, OPC_AUIPC};
            K_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
            K_JALR:  return {imm[11:0], rs1, 3'b000, rd, OPC_JALR};
            K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
            K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, OPC_IMM};
            K_LW:    return {imm[11:0], rs1, 3'b010, rd, OPC_LOAD};
            K_LBU:   return {imm[11:0], rs1, 3'b100, rd, OPC_LOAD};
            K_SW:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
            K_SB:    return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OPC_STORE};
            default: return 32'h0010_0073;
        endcase
    endfunction

    // x0 now and then, x1 never
    function automatic reg_idx_t pick_dest();
        int r;
        r = int'($urandom_range(0, 30));
        return (r == 0) ? 5'd0 : 5'(r + 1);
    endfunction

    // sources only from registers that hold a known value
    function automatic reg_idx_t pick_src();
        reg_idx_t r;
        r = 5'($urandom_range(0, 31));
        while (!reg_known[r]) begin
            r = 5'($urandom_range(0, 31));
        end
        return r;
    endfunction

    task automatic set_slot(input int slot, input int kind, input reg_idx_t rd,
                            input reg_idx_t rs1, input reg_idx_t rs2, input word_t imm,
                            input logic runs);
        slot_kind[slot] = kind;
        slot_rd[slot]   = rd;
        slot_rs1[slot]  = rs1;
        slot_rs2[slot]  = rs2;
        slot_imm[slot]  = imm;
        prog_word[slot] = encode(kind, rd, rs1, rs2, imm);
        // skipped slots leave their rd unknown
        if (runs) begin
            exp_retires++;
            if (kind != K_SW && kind != K_SB && kind != K_EBREAK) begin
                reg_known[rd] = 1'b1;
            end
        end
    endtask

    task automatic gen_simple(input int slot, input logic runs);
        int          sel;
        logic [11:0] imm12;
        word_t       upper;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        sel   = int'($urandom_range(0, 7));
        imm12 = 12'($urandom_range(0, 4095));
        upper = word_t'($urandom) & 32'hffff_f000;
        rd    = pick_dest();
        rs1   = pick_src();
        rs2   = pick_src();
        case (sel)
            0: set_slot(slot, K_ADD, rd, rs1, rs2, '0, runs);
            1: set_slot(slot, K_ADDI, rd, rs1, 5'd0, {{20{imm12[11]}}, imm12}, runs);
            2: set_slot(slot, K_LUI, rd, 5'd0, 5'd0, upper, runs);
            3: set_slot(slot, K_AUIPC, rd, 5'd0, 5'd0, upper, runs);
            // loads and stores are x1 relative, words aligned
            4: set_slot(slot, K_LW, rd, 5'd1, 5'd0,
                        word_t'($urandom_range(0, 511)) * 32'd4, runs);
            5: set_slot(slot, K_LBU, rd, 5'd1, 5'd0, word_t'($urandom_range(0, 2047)), runs);
            6: set_slot(slot, K_SW, 5'd0, 5'd1, rs2,
                        word_t'($urandom_range(0, 511)) * 32'd4, runs);
            default: set_slot(slot, K_SB, 5'd0, 5'd1, rs2,
                              word_t'($urandom_range(0, 2047)), runs);
        endcase
    endtask

    task automatic gen_program();
        int       i;
        int       sel;
        int       skip;
        reg_idx_t tmp;
        exp_retires = 0;
        set_slot(0, K_LUI, 5'd1, 5'd0, 5'd0, 32'h8000_1000, 1'b1);
        i = 1;
        while (i < PROG_LEN - 1) begin
            sel = int'($urandom_range(0, 11));
            if (sel == 10 && i <= PROG_LEN - 3) begin
                // forward jal over one to three slots
                skip = int'($urandom_range(1, 3));
                if (i + skip > PROG_LEN - 2) begin
                    skip = PROG_LEN - 2 - i;
                end
                set_slot(i, K_JAL, pick_dest(), 5'd0, 5'd0, word_t'((skip + 1) * 4), 1'b1);
                for (int j = 1; j <= skip; j++) begin
                    gen_simple(i + j, 1'b0);
                end
                i = i + skip + 1;
            end else if (sel == 11 && i <= PROG_LEN - 4) begin
                // auipc then jalr to pc+12, bit 0 sometimes set
                tmp = 5'($urandom_range(2, 31));
                set_slot(i, K_AUIPC, tmp, 5'd0, 5'd0, '0, 1'b1);
                set_slot(i + 1, K_JALR, pick_dest(), tmp, 5'd0,
                         32'd12 | word_t'($urandom_range(0, 1)), 1'b1);
                gen_simple(i + 2, 1'b0);
                i = i + 3;
            end else begin
                gen_simple(i, 1'b1);
                i = i + 1;
            end
        end
        set_slot(PROG_LEN - 1, K_EBREAK, 5'd0, 5'd0, 5'd0, '0, 1'b1);
    endtask

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        error_count++;
    endtask

    // nothing may retire or store during reset
    task automatic check_quiet();
        if (retire.valid !== 1'b0) begin
            report_mismatch("retire.valid", '0, word_t'(retire.valid));
        end
        if (store.valid !== 1'b0) begin
            report_mismatch("store.valid", '0, word_t'(store.valid));
        end
    endtask

    task automatic load_and_reset(input int prog);
        int slot;
        @(posedge clk);
        #1;
        reset   = 1'b1;
        load_en = 1'b0;
        // program first, then the data window
        for (int w = 0; w < LOAD_WORDS; w++) begin
            @(posedge clk);
            #1;
            slot = (w < PROG_LEN) ? w : DATA_BASE + w - PROG_LEN;
            load_en    = 1'b1;
            load_index = 11'(slot);
            load_data  = (w < PROG_LEN) ? prog_word[w] : data_fill(slot, prog);
            model_mem[slot] = load_data;
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            @(negedge clk);
            check_quiet();
        end
        model_pc     = RESET_PC;
        model_halted = 1'b0;
        @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // execute one slot by isa rules and compare
    task automatic check_retire();
        int         slot;
        int         kind;
        int         wi;
        int         lane;
        word_t      a;
        word_t      b;
        word_t      addr;
        word_t      result;
        word_t      next_pc;
        logic       writes;
        logic       exp_wen;
        logic [3:0] mask;
        logic [7:0] exp_byte;

        slot = int'((model_pc - RESET_PC) >> 2);
        if (retire.pc !== model_pc) begin
            report_mismatch("retire.pc", model_pc, retire.pc);
        end
        if (slot < 0 || slot >= PROG_LEN) begin
            $display("%0t: model pc %h ran outside the program", $time, model_pc);
            error_count++;
            model_halted = 1'b1;
            return;
        end

        kind    = slot_kind[slot];
        a       = model_regs[slot_rs1[slot]];
        b       = model_regs[slot_rs2[slot]];
        addr    = a + slot_imm[slot];
        wi      = int'(((addr - RESET_PC) >> 2) & 32'h0000_07ff);
        lane    = int'(addr[1:0]);
        writes  = 1'b1;
        result  = '0;
        next_pc = model_pc + 32'd4;
        case (kind)
            K_LUI:   result = slot_imm[slot];
            K_AUIPC: result = model_pc + slot_imm[slot];
            K_ADD:   result = a + b;
            K_ADDI:  result = a + slot_imm[slot];
            K_LW:    result = model_mem[wi];
            K_LBU:   result = (model_mem[wi] >> (8 * lane)) & 32'h0000_00ff;
            K_JAL: begin
                result  = model_pc + 32'd4;
                next_pc = model_pc + slot_imm[slot];
            end
            K_JALR: begin
                result  = model_pc + 32'd4;
                next_pc = addr & ~32'd1;
            end
            default: writes = 1'b0;
        endcase

        // x0 writes are no register change
        exp_wen = writes && slot_rd[slot] != 5'd0;
        if (retire.rd_wen !== exp_wen) begin
            report_mismatch("retire.rd_wen", word_t'(exp_wen), word_t'(retire.rd_wen));
        end
        if (exp_wen) begin
            if (retire.rd !== slot_rd[slot]) begin
                report_mismatch("retire.rd", word_t'(slot_rd[slot]), word_t'(retire.rd));
            end
            if (retire.rd_data !== result) begin
                report_mismatch("retire.rd_data", result, retire.rd_data);
            end
            model_regs[slot_rd[slot]] = result;
        end

        if (kind == K_SW || kind == K_SB) begin
            mask = (kind == K_SW) ? 4'b1111 : 4'(1 << lane);
            if (store.valid !== 1'b1) begin
                report_mismatch("store.valid", 32'd1, word_t'(store.valid));
            end
            if (store.addr !== addr) begin
                report_mismatch("store.addr", addr, store.addr);
            end
            if (store.mask !== mask) begin
                report_mismatch("store.mask", word_t'(mask), word_t'(store.mask));
            end
            // only enabled lanes carry meaning
            for (int k = 0; k < 4; k++) begin
                if (mask[k]) begin
                    exp_byte = (kind == K_SW) ? b[8*k +: 8] : b[7:0];
                    if (store.data[8*k +: 8] !== exp_byte) begin
                        report_mismatch("store.data", word_t'(exp_byte),
                                        word_t'(store.data[8*k +: 8]));
                    end
                    model_mem[wi][8*k +: 8] = exp_byte;
                end
            end
            store_count++;
        end else if (store.valid !== 1'b0) begin
            report_mismatch("store.valid", '0, word_t'(store.valid));
        end

        if (kind == K_EBREAK) begin
            model_halted = 1'b1;
        end else begin
            model_pc = next_pc;
        end
    endtask

    task automatic run_program(input int prog);
        int cycles;
        int seen;
        cycles = 0;
        seen   = 0;
        while (!model_halted && cycles < PROG_LEN + SLACK) begin
            @(negedge clk);
            cycles++;
            if (retire.valid === 1'b1) begin
                if (seen == 0 && retire.pc !== RESET_PC) begin
                    report_mismatch("first retire.pc", RESET_PC, retire.pc);
                end
                seen++;
                check_retire();
            end else begin
                report_mismatch("retire.valid", 32'd1, word_t'(retire.valid));
            end
        end
        if (!model_halted) begin
            $display("%0t: program %0d never reached its ebreak", $time, prog);
            error_count++;
        end
        // core must sit halted and silent
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                report_mismatch("halted", 32'd1, word_t'(halted));
            end
            // a retire past the ebreak adds to the total
            if (retire.valid === 1'b1) begin
                seen++;
            end
            check_quiet();
        end
        if (seen != exp_retires) begin
            report_mismatch("retire count", word_t'(exp_retires), word_t'(seen));
        end
        retire_count += seen;
    endtask

    initial begin
        int unsigned seed_ret;
        seed_ret     = $urandom(32'h3bf7_967e);
        error_count  = 0;
        retire_count = 0;
        store_count  = 0;
        reset        = 1'b1;
        load_en      = 1'b0;
        load_index   = '0;
        load_data    = '0;
        model_pc     = RESET_PC;
        model_halted = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
            reg_known[r]  = (r < 2);
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            gen_program();
            load_and_reset(p);
            run_program(p);
        end
        error_count += dut.u_assertions.fail_count;
        $display("errors %0d, instructions retired %0d, stores %0d",
                 error_count, retire_count, store_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // bound from the load, reset and run lengths
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the run finished", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule
